// File: Bender.yml
package:
  name: mem_ctrl

sources:
  - files:
      - verilog/memCtrlPkg.sv
      - verilog/fetchSequencer.sv
      - verilog/dataSequencer.sv
      - verilog/memArbiter.sv
      - verilog/memCtrl.sv
  - target: test
    files:
      - verif/byteRam.sv
      - verif/memCtrlTb.sv

// File: build.f
verilog/memCtrlPkg.sv
verilog/fetchSequencer.sv
verilog/dataSequencer.sv
verilog/memArbiter.sv
verilog/memCtrl.sv
verif/byteRam.sv
verif/memCtrlTb.sv

// File: verif/byteRam.sv
`timescale 1ns/10ps

module byteRam #(
    parameter int addrWidth = 12
) (
    input  logic                 clk,
    input  logic [addrWidth-1:0] addr,
    input  logic [7:0]           wdata,
    input  logic                 write,
    output logic [7:0]           rdata
);

    logic [7:0] mem [1 << addrWidth];

    // read data one cycle after address, old byte on a write
    always @(posedge clk) begin
        if (write) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: verif/memCtrlTb.sv
`timescale 1ns/10ps

module memCtrlTb
    import memCtrlPkg::*;
();

    localparam int addrWidth = 12;
    localparam int memBytes = 1 << addrWidth;
    localparam int timeoutCycles = 40;

    logic clk, rst, rdy, ioBufferFull;
    logic fetchEn, fetchDone, fetchStall, dataEn, dataDone, dataStall;
    logic [31:0] fetchAddr, fetchInst, dataRdata;
    dataReq_t dataReq;
    logic [addrWidth-1:0] ramAddr;
    logic [7:0] ramWdata, ramRdata;
    logic ramWrite;

    // expected memory contents
    logic [7:0] mirror [memBytes];
    int errors = 0, testsRun = 0, testsFailed = 0;
    // freeze window in cycles after the request, zero length is none
    int freezeAt = 0, freezeLen = 0;
    logic freezeIo = 1'b0;

    memCtrl #(.addrWidth(addrWidth)) i_dut (.*);

    byteRam #(.addrWidth(addrWidth)) i_ram (
        .clk(clk), .addr(ramAddr), .wdata(ramWdata), .write(ramWrite), .rdata(ramRdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compareValue(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // little endian, zero above n bytes
    function automatic logic [31:0] mirrorWord(logic [31:0] addr, int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = mirror[addr + i];
        end
        return w;
    endfunction

    function automatic logic [31:0] randomAligned(int limit);
        return ($urandom % limit) & ~32'd3;
    endfunction

    task automatic reportTest(string name, int start);
        testsRun++;
        testsFailed += (errors != start);
        $display("%s: %0d errors", name, errors - start);
    endtask

    // raise the wanted enables, drop each on its done pulse
    task automatic runTransfer(input logic wantFetch, input logic wantData,
                               output int fetchCycle, output int dataCycle);
        int cycles = 0;
        logic frozen = 1'b0;
        fetchEn = wantFetch;
        dataEn = wantData;
        fetchCycle = 0;
        dataCycle = 0;
        while ((fetchEn || dataEn) && cycles < timeoutCycles) begin
            @(negedge clk);
            cycles++;
            if (frozen) begin
                compareValue("fetchDone,dataDone", {fetchDone, dataDone}, 2'b00);
            end
            // data wins a shared start, fetch sits stalled
            if (fetchEn && dataEn) begin
                compareValue("fetchStall,fetchDone", {fetchStall, fetchDone}, 2'b10);
            end
            if (fetchEn && fetchDone) begin
                fetchCycle = cycles;
                fetchEn = 1'b0;
            end
            if (dataEn && dataDone) begin
                dataCycle = cycles;
                dataEn = 1'b0;
            end
            frozen = cycles >= freezeAt && cycles < freezeAt + freezeLen;
            rdy = ~(frozen & ~freezeIo);
            ioBufferFull = frozen & freezeIo;
        end
        if (fetchEn || dataEn) begin
            $display("Timeout: no done pulse within %0d cycles at %0t", timeoutCycles, $time);
            errors++;
        end
        fetchEn = 1'b0;
        dataEn = 1'b0;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        @(negedge clk);
    endtask

    task automatic fetchOne(logic [31:0] addr);
        int fetchCycle, dataCycle;
        fetchAddr = addr;
        runTransfer(1'b1, 1'b0, fetchCycle, dataCycle);
        compareValue("fetchInst", fetchInst, mirrorWord(addr, 4));
        compareValue("fetch cycles", fetchCycle, 5 + freezeLen);
    endtask

    task automatic dataAccess(memOp_e op, memLen_e len, logic [31:0] addr, logic [31:0] wdata);
        int n, fetchCycle, dataCycle;
        n = 1 << int'(len);
        dataReq = '{op: op, len: len, addr: addr, wdata: wdata};
        runTransfer(1'b0, 1'b1, fetchCycle, dataCycle);
        if (op == opStore) begin
            for (int i = 0; i < n; i++) begin
                mirror[addr + i] = wdata[8*i +: 8];
            end
            compareValue("store cycles", dataCycle, n + freezeLen);
        end else begin
            compareValue("dataRdata", dataRdata, mirrorWord(addr, n));
            compareValue("load cycles", dataCycle, n + 1 + freezeLen);
        end
    endtask

    task automatic dumpCompare();
        for (int a = 0; a < memBytes; a++) begin
            if (i_ram.mem[a] !== mirror[a]) begin
                compareValue($sformatf("ram[%0h]", a), i_ram.mem[a], mirror[a]);
            end
        end
    endtask

    task automatic pickFreeze(int maxAt);
        freezeIo = 1'($urandom);
        freezeAt = 1 + $urandom % maxAt;
        freezeLen = 1 + $urandom % 6;
    endtask

    task automatic resetValues();
        int start = errors;
        compareValue("fetchDone,dataDone,fetchStall,dataStall,ramWrite",
                     {fetchDone, dataDone, fetchStall, dataStall, ramWrite}, 5'b0);
        reportTest("reset values", start);
    endtask

    task automatic randomFetches();
        int start = errors;
        repeat (6) fetchOne(randomAligned(memBytes));
        reportTest("fetch", start);
    endtask

    task automatic loadLengths();
        int start = errors;
        for (int i = 0; i < 6; i++) begin
            dataAccess(opLoad, memLen_e'(i % 3), randomAligned(memBytes), 32'h0);
        end
        reportTest("loads", start);
    endtask

    task automatic storeLengths();
        int start = errors;
        logic [31:0] addr;
        for (int i = 0; i < 3; i++) begin
            addr = randomAligned(memBytes - 8);
            dataAccess(opStore, memLen_e'(i), addr, $urandom);
            // neighbors show the untouched bytes
            dataAccess(opLoad, lenWord, addr, 32'h0);
            dataAccess(opLoad, lenWord, addr + 4, 32'h0);
        end
        dumpCompare();
        reportTest("stores", start);
    endtask

    task automatic sharedStart();
        int start = errors;
        int fetchCycle, dataCycle;
        fetchAddr = randomAligned(memBytes);
        dataReq = '{op: opLoad, len: lenWord, addr: randomAligned(memBytes), wdata: 32'h0};
        runTransfer(1'b1, 1'b1, fetchCycle, dataCycle);
        compareValue("dataRdata", dataRdata, mirrorWord(dataReq.addr, 4));
        compareValue("fetchInst", fetchInst, mirrorWord(fetchAddr, 4));
        compareValue("data cycles", dataCycle, 5);
        compareValue("fetch cycles", fetchCycle, dataCycle + 5);
        reportTest("shared start", start);
    endtask

    task automatic frozenTransfers();
        int start = errors;
        for (int i = 0; i < 4; i++) begin
            // window must open before the nominal done
            pickFreeze(4);
            fetchOne(randomAligned(memBytes));
            pickFreeze(3);
            dataAccess(opStore, lenWord, randomAligned(memBytes), $urandom);
        end
        freezeLen = 0;
        dumpCompare();
        reportTest("freeze", start);
    endtask

    initial begin
        void'($urandom(32'haad0943c));
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataReq = '0;
        for (int a = 0; a < memBytes; a++) begin
            mirror[a] = 8'($urandom);
            i_ram.mem[a] = mirror[a];
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        resetValues();
        randomFetches();
        loadLengths();
        storeLengths();
        sharedStart();
        frozenTransfers();
        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/dataSequencer.sv
`timescale 1ns/10ps

module dataSequencer
    import memCtrlPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        dataEn,
    input  dataReq_t    dataReq,
    input  logic        dataGo,
    input  logic [7:0]  ramRdata,
    output memPort_t    dataPort,
    output logic        dataBusy,
    output logic        dataDone,
    output logic [31:0] dataRdata
);

    logic [2:0] step;
    logic [2:0] nBytes;
    logic [1:0] storeLane;
    logic [1:0] loadLane;
    logic       isStore;
    logic       isLast;
    logic       active;
    logic       advance;
    memWord_u   reqWord;
    memWord_u   acc;

    always_comb begin
        case (dataReq.len)
            lenByte: nBytes = 3'd1;
            lenHalf: nBytes = 3'd2;
            default: nBytes = 3'd4;
        endcase
    end

    assign isStore = (dataReq.op == opStore);

    // no new transfer starts in the done cycle
    assign active  = dataBusy | (dataEn & ~dataDone);
    assign advance = dataGo & active;

    // store ends on its last write, load one step after its last address
    assign isLast = isStore ? (step == nBytes - 3'd1) : (step == nBytes);

    assign storeLane = step[1:0];
    assign loadLane  = 2'(step - 3'd1);

    assign reqWord.word = dataReq.wdata;

    always_comb begin
        dataPort.addr  = dataReq.addr + 32'(step);
        dataPort.wdata = reqWord.bytes[storeLane];
        dataPort.write = isStore & active;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step     <= 3'd0;
            dataBusy <= 1'b0;
            dataDone <= 1'b0;
        end else begin
            dataDone <= 1'b0;
            if (advance) begin
                if (isLast) begin
                    step     <= 3'd0;
                    dataBusy <= 1'b0;
                    dataDone <= 1'b1;
                end else begin
                    step     <= step + 3'd1;
                    dataBusy <= 1'b1;
                end
            end
        end
    end

    // cleared at start so short loads come out zero extended
    always_ff @(posedge clk) begin
        if (advance && !isStore) begin
            if (step == 3'd0) begin
                acc.word <= 32'h0;
            end else begin
                acc.bytes[loadLane] <= ramRdata;
            end
        end
    end

    assign dataRdata = acc.word;

    assert property (@(posedge clk) disable iff (rst)
        dataEn |-> dataReq.len inside {lenByte, lenHalf, lenWord})
        else $error("illegal data length %0d", dataReq.len);

endmodule

// File: verilog/fetchSequencer.sv
`timescale 1ns/10ps

module fetchSequencer
    import memCtrlPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetchEn,
    input  logic [31:0] fetchAddr,
    input  logic        fetchGo,
    input  logic [7:0]  ramRdata,
    output memPort_t    fetchPort,
    output logic        fetchBusy,
    output logic        fetchDone,
    output logic [31:0] fetchInst
);

    localparam logic [2:0] lastStep = 3'(wordBytes);

    logic [2:0] step;
    logic [1:0] lane;
    logic       advance;
    memWord_u   acc;

    // a go in the done cycle belongs to the finished fetch, ignore it
    assign advance = fetchGo & fetchEn & (fetchBusy | ~fetchDone);

    // byte coming back now was addressed one step earlier
    assign lane = 2'(step - 3'd1);

    always_comb begin
        fetchPort.addr  = fetchAddr + 32'(step);
        fetchPort.wdata = 8'h00;
        fetchPort.write = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step      <= 3'd0;
            fetchBusy <= 1'b0;
            fetchDone <= 1'b0;
        end else begin
            fetchDone <= 1'b0;
            if (advance) begin
                if (step == lastStep) begin
                    step      <= 3'd0;
                    fetchBusy <= 1'b0;
                    fetchDone <= 1'b1;
                end else begin
                    step      <= step + 3'd1;
                    fetchBusy <= 1'b1;
                end
            end
        end
    end

    // all four lanes get written, so no clear at start
    always_ff @(posedge clk) begin
        if (advance && step != 3'd0) begin
            acc.bytes[lane] <= ramRdata;
        end
    end

    assign fetchInst = acc.word;

    // one pulse per fetch, the next needs at least four steps
    assert property (@(posedge clk) disable iff (rst) fetchDone |=> !fetchDone)
        else $error("fetchDone high two cycles in a row");

endmodule

// File: verilog/memArbiter.sv
`timescale 1ns/10ps

module memArbiter
    import memCtrlPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     fetchEn,
    input  logic     dataEn,
    input  logic     fetchBusy,
    input  logic     dataBusy,
    input  logic     rdy,
    input  logic     ioBufferFull,
    input  memPort_t fetchPort,
    input  memPort_t dataPort,
    output memPort_t ramPort,
    output logic     fetchGo,
    output logic     dataGo,
    output logic     fetchStall,
    output logic     dataStall
);

    logic     frozen;
    logic     dataSel;
    logic     dataOwnerQ;
    logic     fetchWant;
    logic     dataWant;
    memPort_t muxPort;
    memPort_t heldPort;

    assign frozen = ~rdy | ioBufferFull;

    assign fetchWant = fetchEn | fetchBusy;
    assign dataWant  = dataEn | dataBusy;

    // owner holds while a transfer runs, data wins a fresh start
    always_comb begin
        if (fetchBusy || dataBusy) begin
            dataSel = dataOwnerQ;
        end else if (dataEn) begin
            dataSel = 1'b1;
        end else if (fetchEn) begin
            dataSel = 1'b0;
        end else begin
            dataSel = dataOwnerQ;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dataOwnerQ <= 1'b0;
        end else begin
            dataOwnerQ <= dataSel;
        end
    end

    assign fetchGo = ~frozen & ~dataSel & fetchWant;
    assign dataGo  = ~frozen & dataSel & dataWant;

    assign muxPort = dataSel ? dataPort : fetchPort;

    // replay the last live port as a read while frozen
    always_ff @(posedge clk) begin
        if (!frozen) begin
            heldPort <= muxPort;
        end
    end

    always_comb begin
        if (frozen) begin
            ramPort.addr  = heldPort.addr;
            ramPort.wdata = heldPort.wdata;
            ramPort.write = 1'b0;
        end else begin
            ramPort = muxPort;
        end
    end

    assign fetchStall = fetchBusy | (dataSel & dataWant);
    assign dataStall  = dataBusy | (~dataSel & fetchWant);

    assert property (@(posedge clk) disable iff (rst) !(fetchGo && dataGo))
        else $error("both sequencers advanced in one cycle");

    // busy comes from the sequencers, owner from here
    assert property (@(posedge clk) disable iff (rst)
        !(dataBusy && !dataOwnerQ) && !(fetchBusy && dataOwnerQ))
        else $error("grant moved while owner busy");

endmodule

// File: verilog/memCtrl.sv
`timescale 1ns/10ps

module memCtrl
    import memCtrlPkg::*;
#(
    parameter int addrWidth = 17
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,

    // instruction fetch client
    input  logic                 fetchEn,
    input  logic [31:0]          fetchAddr,
    output logic                 fetchDone,
    output logic [31:0]          fetchInst,
    output logic                 fetchStall,

    // data client
    input  logic                 dataEn,
    input  dataReq_t             dataReq,
    output logic                 dataDone,
    output logic [31:0]          dataRdata,
    output logic                 dataStall,

    // byte RAM, read data one cycle after address
    output logic [addrWidth-1:0] ramAddr,
    output logic [7:0]           ramWdata,
    output logic                 ramWrite,
    input  logic [7:0]           ramRdata
);

    memPort_t fetchPort;
    memPort_t dataPort;
    memPort_t ramPort;
    logic     fetchGo;
    logic     dataGo;
    logic     fetchBusy;
    logic     dataBusy;

    fetchSequencer i_fetchSequencer (
        .clk       (clk),
        .rst       (rst),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchGo   (fetchGo),
        .ramRdata  (ramRdata),
        .fetchPort (fetchPort),
        .fetchBusy (fetchBusy),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst)
    );

    dataSequencer i_dataSequencer (
        .clk       (clk),
        .rst       (rst),
        .dataEn    (dataEn),
        .dataReq   (dataReq),
        .dataGo    (dataGo),
        .ramRdata  (ramRdata),
        .dataPort  (dataPort),
        .dataBusy  (dataBusy),
        .dataDone  (dataDone),
        .dataRdata (dataRdata)
    );

    memArbiter i_memArbiter (
        .clk          (clk),
        .rst          (rst),
        .fetchEn      (fetchEn),
        .dataEn       (dataEn),
        .fetchBusy    (fetchBusy),
        .dataBusy     (dataBusy),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchPort    (fetchPort),
        .dataPort     (dataPort),
        .ramPort      (ramPort),
        .fetchGo      (fetchGo),
        .dataGo       (dataGo),
        .fetchStall   (fetchStall),
        .dataStall    (dataStall)
    );

    assign ramAddr  = ramPort.addr[addrWidth-1:0];
    assign ramWdata = ramPort.wdata;
    assign ramWrite = ramPort.write;

endmodule

// File: verilog/memCtrlPkg.sv
package memCtrlPkg;

    // bytes in one memory word
    localparam int wordBytes = 4;

    // access length of a data request
    typedef enum logic [1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd2
    } memLen_e;

    typedef enum logic {
        opLoad  = 1'b0,
        opStore = 1'b1
    } memOp_e;

    // one word, seen whole or as little endian bytes
    // byte 0 is the least significant lane
    typedef union packed {
        logic [31:0]                word;
        logic [wordBytes-1:0][7:0]  bytes;
    } memWord_u;

    // single byte access toward the RAM
    // addr is cut down to the RAM width at the top
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  wdata;
        logic        write;
    } memPort_t;

    // data client request, held stable until done
    typedef struct packed {
        memOp_e      op;
        memLen_e     len;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dataReq_t;

endpackage
